/* build.f */
verilog/dcache_pkg.sv
verilog/dcache_way_if.sv
verilog/dcache_req_latch.sv
verilog/dcache_way.sv
verilog/dcache_way_select.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
testbench/dcache_sva.sv
testbench/dcache_checker.sv
testbench/tb_dcache.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_dcache -f build.f --Mdir "$build_dir" -o tb_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/tb_dcache" > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -qx "STATUS: PASS" "$log_file"; then
    exit 0
fi
exit 1

/* testbench/dcache_checker.sv */
module dcache_checker import dcache_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    req_valid,
    input  logic    req_ready,
    input  addr_t   req_addr,
    input  strobe_t req_strobe,
    input  word_t   req_wdata,
    input  logic    resp_valid,
    input  logic    resp_ready,
    input  word_t   resp_rdata,
    input  logic    mem_valid,
    input  logic    mem_ready,
    input  logic    mem_write,
    input  addr_t   mem_addr,
    input  word_t   mem_wdata,
    input  logic    exp_hit,
    output int      value_errors,
    output int      protocol_errors
);
    timeunit 1ns;
    timeprecision 100ps;

    word_t shadow_mem [addr_t];
    logic  sh_valid [num_sets][num_ways];
    logic  sh_dirty [num_sets][num_ways];
    tag_t  sh_tag   [num_sets][num_ways];
    plru_t sh_plru  [num_sets];

    addr_t cur_addr;
    logic  pred_hit;
    logic  pred_wb;
    addr_t line_addr;
    addr_t victim_addr;
    word_t exp_rdata;
    int    rd_beats;
    int    wr_beats;
    logic  stalled;
    word_t stalled_rdata;

    // same start pattern as the memory model
    function automatic word_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    function automatic word_t shadow_word(addr_t a);
        return shadow_mem.exists(a) ? shadow_mem[a] : fill_word(a);
    endfunction

    task automatic predict(addr_t a, strobe_t strobe, word_t wdata);
        index_t   idx;
        tag_t     tg;
        way_sel_t way;
        addr_t    wa;
        word_t    merged;
        idx      = a[5:4];
        tg       = a[31:6];
        wa       = {a[31:2], 2'b00};
        cur_addr = a;
        pred_hit = 1'b0;
        if (!sh_plru[idx][0]) begin
            way = sh_plru[idx][1] ? 2'd1 : 2'd0;
        end else begin
            way = sh_plru[idx][2] ? 2'd3 : 2'd2;
        end
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!sh_valid[idx][w]) begin
                way = way_sel_t'(w); // free way beats the tree
            end
        end
        for (int w = 0; w < num_ways; w++) begin
            if (sh_valid[idx][w] && sh_tag[idx][w] == tg) begin
                pred_hit = 1'b1;
                way      = way_sel_t'(w);
            end
        end
        pred_wb     = !pred_hit && sh_valid[idx][way] && sh_dirty[idx][way];
        victim_addr = {sh_tag[idx][way], idx, 4'h0};
        line_addr   = {a[31:4], 4'h0};
        merged      = shadow_word(wa);
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) begin
                merged[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        shadow_mem[wa]     = merged;
        exp_rdata          = merged;
        sh_dirty[idx][way] = (pred_hit && sh_dirty[idx][way]) || (|strobe);
        sh_valid[idx][way] = 1'b1;
        sh_tag[idx][way]   = tg;
        if (way < 2'd2) begin
            sh_plru[idx][0] = 1'b1;
            sh_plru[idx][1] = (way == 2'd0);
        end else begin
            sh_plru[idx][0] = 1'b0;
            sh_plru[idx][2] = (way == 2'd2);
        end
        rd_beats = 0;
        wr_beats = 0;
    endtask

    task automatic check_beat();
        word_t exp_wdata;
        if (mem_write) begin
            exp_wdata = shadow_word(victim_addr + addr_t'(wr_beats * 4));
            if (!pred_wb || wr_beats >= 4) begin
                $display("unexpected write-back beat during access to 0x%h", cur_addr);
                protocol_errors++;
            end else if (mem_addr != victim_addr) begin
                $display("Error: mem_addr expected 0x%h got 0x%h", victim_addr, mem_addr);
                value_errors++;
            end else if (mem_wdata != exp_wdata) begin
                $display("Error: mem_wdata expected 0x%h got 0x%h", exp_wdata, mem_wdata);
                value_errors++;
            end
            wr_beats++;
        end else begin
            if (pred_hit || rd_beats >= 4) begin
                $display("unexpected refill beat during access to 0x%h", cur_addr);
                protocol_errors++;
            end else if (pred_wb && wr_beats < 4) begin
                $display("refill for 0x%h started before the write-back finished", cur_addr);
                protocol_errors++;
            end else if (mem_addr != line_addr) begin
                $display("Error: mem_addr expected 0x%h got 0x%h", line_addr, mem_addr);
                value_errors++;
            end
            rd_beats++;
        end
    endtask

    task automatic check_response();
        if (resp_rdata != exp_rdata) begin
            $display("Error: resp_rdata expected 0x%h got 0x%h", exp_rdata, resp_rdata);
            value_errors++;
        end
        if (rd_beats != (pred_hit ? 0 : 4) || wr_beats != (pred_wb ? 4 : 0)) begin
            $display(
                "access to 0x%h saw %0d refill and %0d write-back beats, expected %0d and %0d",
                cur_addr, rd_beats, wr_beats, pred_hit ? 0 : 4, pred_wb ? 4 : 0);
            protocol_errors++;
        end
        if ((rd_beats == 0) != exp_hit) begin
            $display("hit or miss of 0x%h differs from the stimulus table", cur_addr);
            protocol_errors++;
        end
    endtask

    // all bus activity is sampled at negedge
    always @(negedge clk) begin
        if (resetn) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    sh_valid[s][w] = 1'b0;
                    sh_dirty[s][w] = 1'b0;
                end
                sh_plru[s] = '0;
            end
            shadow_mem.delete();
            stalled         = 1'b0;
            value_errors    = 0;
            protocol_errors = 0;
        end else begin
            if (stalled && !(resp_valid && resp_rdata == stalled_rdata && !req_ready)) begin
                $display("response changed or a request was taken while resp_ready was low");
                protocol_errors++;
            end
            stalled       = resp_valid && !resp_ready;
            stalled_rdata = resp_rdata;
            if (req_valid && req_ready) begin
                predict(req_addr, req_strobe, req_wdata);
            end
            if (mem_valid && mem_ready) begin
                check_beat();
            end
            if (resp_valid && resp_ready) begin
                check_response();
            end
        end
    end

endmodule

/* testbench/dcache_sva.sv */
module dcache_sva import dcache_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    input  logic  req_pending,
    input  logic  resp_valid,
    input  logic  resp_ready,
    input  word_t resp_rdata,
    input  logic  mem_valid,
    input  logic  mem_ready,
    input  logic  mem_last,
    input  addr_t mem_addr
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    resp_stable: assert property (@(posedge clk) disable iff (resetn)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
        else begin
            $error("response dropped or changed while resp_ready was low");
            fail_count++;
        end

    busy_while_resp: assert property (@(posedge clk) disable iff (resetn)
        resp_valid |-> req_pending) // no new request during a response
        else begin
            $error("cache ready for a request while a response is pending");
            fail_count++;
        end

    burst_addr_stable: assert property (@(posedge clk) disable iff (resetn)
        mem_valid && !(mem_ready && mem_last) |=> mem_valid && $stable(mem_addr))
        else begin
            $error("memory burst address changed before the last beat");
            fail_count++;
        end

endmodule

bind dcache_ctrl dcache_sva i_sva (.*);

/* testbench/tb_dcache.sv */
module tb_dcache import dcache_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period       = 8;
    localparam int num_entries      = 24;
    localparam int cycles_per_entry = 80;

    typedef struct packed {
        addr_t   addr;
        strobe_t strobe;
        word_t   wdata;
        logic    hit;    // expected lookup result
    } stim_t;

    // set 1 gets nine tags, sets 2 and 3 a few accesses
    stim_t stim [num_entries] = '{
        '{32'h0000_0010, 4'b0000, 32'h0000_0000, 1'b0},
        '{32'h0000_0014, 4'b0000, 32'h0000_0000, 1'b1},
        '{32'h0000_0018, 4'b0110, 32'hdead_beef, 1'b1},
        '{32'h0000_0018, 4'b0000, 32'h0000_0000, 1'b1},
        '{32'h0000_0050, 4'b0000, 32'h0000_0000, 1'b0},
        '{32'h0000_0090, 4'b1111, 32'h1234_5678, 1'b0},
        '{32'h0000_00d0, 4'b0000, 32'h0000_0000, 1'b0},
        '{32'h0000_0010, 4'b0000, 32'h0000_0000, 1'b1},
        '{32'h0000_0110, 4'b0000, 32'h0000_0000, 1'b0}, // dirty way 2 goes
        '{32'h0000_0090, 4'b0000, 32'h0000_0000, 1'b0},
        '{32'h0000_0054, 4'b0000, 32'h0000_0000, 1'b0},
        '{32'h0000_001c, 4'b1000, 32'ha5a5_a5a5, 1'b1},
        '{32'h0000_0020, 4'b0000, 32'h0000_0000, 1'b0},
        '{32'h0000_0024, 4'b0001, 32'h0000_00c3, 1'b1},
        '{32'h0000_0110, 4'b0000, 32'h0000_0000, 1'b1},
        '{32'h0000_001c, 4'b0000, 32'h0000_0000, 1'b1},
        '{32'h0000_0150, 4'b0000, 32'h0000_0000, 1'b0},
        '{32'h0000_0190, 4'b0000, 32'h0000_0000, 1'b0},
        '{32'h0000_01d0, 4'b0000, 32'h0000_0000, 1'b0},
        '{32'h0000_0210, 4'b0000, 32'h0000_0000, 1'b0}, // dirty way 0 goes
        '{32'h0000_0018, 4'b0000, 32'h0000_0000, 1'b0},
        '{32'h0000_0038, 4'b0011, 32'h7e57_0f0f, 1'b0},
        '{32'h0000_0038, 4'b0000, 32'h0000_0000, 1'b1},
        '{32'h0000_0090, 4'b0000, 32'h0000_0000, 1'b0}
    };

    logic    clk = 1'b0;
    logic    resetn;
    logic    req_valid;
    logic    req_ready;
    addr_t   req_addr;
    strobe_t req_strobe;
    word_t   req_wdata;
    logic    resp_valid;
    logic    resp_ready = 1'b0;
    word_t   resp_rdata;
    logic    mem_valid;
    logic    mem_ready = 1'b0;
    logic    mem_write;
    addr_t   mem_addr;
    word_t   mem_wdata;
    word_t   mem_rdata = '0;
    logic    mem_last = 1'b0;
    logic    exp_hit;
    int      value_errors;
    int      protocol_errors;
    int      assert_errors;
    integer  seed = 32'h3d2a;
    word_t   mem_model [addr_t];
    int      beat = 0;

    dcache_top i_dut (.*);

    dcache_checker i_checker (.*);

    always #(clk_period / 2) clk = ~clk;

    function automatic word_t mem_word(addr_t a);
        return mem_model.exists(a) ? mem_model[a] : {a[15:0], a[31:16]} ^ 32'h9e37_79b9;
    endfunction

    // memory model, also owns the random resp_ready
    always begin
        @(negedge clk);
        if (mem_valid && mem_ready) begin
            if (mem_write) begin
                mem_model[mem_addr + addr_t'(beat * 4)] = mem_wdata;
            end
            beat = (beat + 1) % 4;
        end
        @(posedge clk);
        #1;
        mem_ready  = ($random(seed) & 3) != 0;
        resp_ready = ($random(seed) & 7) != 0;
        mem_last   = (beat == 3);
        mem_rdata  = mem_word(mem_addr + addr_t'(beat * 4));
    end

    task automatic apply_entry(input stim_t e);
        req_valid  = 1'b1;
        req_addr   = e.addr;
        req_strobe = e.strobe;
        req_wdata  = e.wdata;
        exp_hit    = e.hit;
        do @(negedge clk); while (!req_ready);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        do @(negedge clk); while (!(resp_valid && resp_ready));
        @(posedge clk);
        #1;
    endtask

    initial begin
        resetn     = 1'b1;
        req_valid  = 1'b0;
        req_addr   = '0;
        req_strobe = '0;
        req_wdata  = '0;
        exp_hit    = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b0;
        foreach (stim[i]) begin
            apply_entry(stim[i]);
        end
        repeat (2) @(posedge clk);
        assert_errors = i_dut.i_ctrl.i_sva.fail_count;
        $display("errors: value %0d, protocol %0d, assertion %0d",
                 value_errors, protocol_errors, assert_errors);
        if (value_errors + protocol_errors + assert_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(num_entries * cycles_per_entry * clk_period);
        $display("watchdog expired before the stimulus table was done");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* verilog/dcache_ctrl.sv */
module dcache_ctrl import dcache_pkg::*; (
    input  logic          clk,
    input  logic          resetn,
    input  logic          req_pending,
    input  tag_t          held_tag,
    input  index_t        held_index,
    input  word_sel_t     held_word,
    input  strobe_t       held_strobe,
    input  word_t         held_wdata,
    output logic          access_done,
    input  logic          sel_hit,
    input  way_sel_t      sel_way,
    input  logic          sel_dirty,
    input  tag_t          sel_tag,
    input  line_t         sel_line,
    dcache_way_if.writer  ways [num_ways],
    output logic          resp_valid,
    input  logic          resp_ready,
    output word_t         resp_rdata,
    output logic          mem_valid,
    input  logic          mem_ready,
    output logic          mem_write,
    output addr_t         mem_addr,
    output word_t         mem_wdata,
    input  word_t         mem_rdata,
    input  logic          mem_last
);

    function automatic word_t get_word(line_t line, word_sel_t sel);
        return line[sel * word_bits +: word_bits];
    endfunction

    function automatic line_t put_word(line_t line, word_sel_t sel, word_t w);
        line_t result;
        result = line;
        result[sel * word_bits +: word_bits] = w;
        return result;
    endfunction

    function automatic word_t merge_word(word_t old_word, word_t new_word, strobe_t strobe);
        word_t result;
        result = old_word;
        for (int b = 0; b < $bits(strobe_t); b++) begin
            if (strobe[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    word_sel_t   beat_q;
    way_sel_t    victim_q;
    line_t       fill_q;
    word_t       resp_rdata_q;

    logic                is_write;
    logic                mem_fire;
    logic [num_ways-1:0] wr_en_vec;
    line_t               wr_line_c;
    logic                wr_dirty_c;
    line_t               hit_line;
    line_t               fill_line;
    line_t               refill_line;

    assign is_write = |held_strobe;
    assign mem_fire = mem_valid && mem_ready;

    // a zero strobe leaves the line as it is
    assign hit_line    = put_word(sel_line, held_word,
                                  merge_word(get_word(sel_line, held_word), held_wdata,
                                             held_strobe));
    assign fill_line   = put_word(fill_q, beat_q, mem_rdata);
    assign refill_line = put_word(fill_line, held_word,
                                  merge_word(get_word(fill_line, held_word), held_wdata,
                                             held_strobe));

    always_comb begin
        state_d     = state_q;
        access_done = 1'b0;
        wr_en_vec   = '0;
        wr_line_c   = hit_line;
        wr_dirty_c  = 1'b1;
        mem_valid   = 1'b0;
        mem_write   = 1'b0;
        mem_addr    = {held_tag, held_index, {index_lsb{1'b0}}};
        mem_wdata   = get_word(sel_line, beat_q);
        unique case (state_q)
            IDLE: begin
                if (req_pending) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (sel_hit) begin
                    wr_en_vec[sel_way] = is_write; // write hit stores dirty
                    state_d            = RESPOND;
                end else if (sel_dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            WRITEBACK: begin
                mem_valid = 1'b1;
                mem_write = 1'b1;
                mem_addr  = {sel_tag, held_index, {index_lsb{1'b0}}}; // victim line
                if (mem_fire && mem_last) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                mem_valid = 1'b1;
                if (mem_fire && mem_last) begin
                    wr_en_vec[victim_q] = 1'b1;
                    wr_line_c           = refill_line;
                    wr_dirty_c          = is_write;
                    state_d             = RESPOND;
                end
            end
            RESPOND: begin
                if (resp_ready) begin
                    access_done = 1'b1;
                    state_d     = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    for (genvar w = 0; w < num_ways; w++) begin : g_write
        assign ways[w].wr_en    = wr_en_vec[w];
        assign ways[w].wr_line  = wr_line_c;
        assign ways[w].wr_dirty = wr_dirty_c;
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            state_q <= IDLE;
            beat_q  <= '0;
        end else begin
            state_q <= state_d;
            if (mem_fire) begin
                beat_q <= mem_last ? '0 : beat_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == LOOKUP) begin
            victim_q <= sel_way;
            if (sel_hit) begin
                resp_rdata_q <= get_word(hit_line, held_word);
            end
        end
        if (state_q == REFILL && mem_fire) begin
            fill_q <= fill_line;
            if (mem_last) begin
                resp_rdata_q <= get_word(refill_line, held_word);
            end
        end
    end

    assign resp_valid = (state_q == RESPOND);
    assign resp_rdata = resp_rdata_q;

endmodule

/* verilog/dcache_pkg.sv */
package dcache_pkg;

    localparam int num_ways       = 4;
    localparam int num_sets       = 4;
    localparam int words_per_line = 4;
    localparam int word_bits      = 32;

    // address split, byte offset sits below word_lsb
    localparam int word_lsb  = 2;
    localparam int index_lsb = word_lsb + $clog2(words_per_line);
    localparam int tag_lsb   = index_lsb + $clog2(num_sets);
    localparam int tag_bits  = 32 - tag_lsb;

    typedef logic [word_bits-1:0]                word_t;
    typedef logic [31:0]                         addr_t;
    typedef logic [word_bits/8-1:0]              strobe_t;
    typedef logic [tag_bits-1:0]                 tag_t;
    typedef logic [$clog2(num_sets)-1:0]         index_t;
    typedef logic [$clog2(words_per_line)-1:0]   word_sel_t;
    typedef logic [$clog2(num_ways)-1:0]         way_sel_t;
    typedef logic [words_per_line*word_bits-1:0] line_t; // word 0 in the low bits
    typedef logic [num_ways-2:0]                 plru_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } ctrl_state_t;

endpackage

/* verilog/dcache_req_latch.sv */
module dcache_req_latch import dcache_pkg::*; (
    input  logic                clk,
    input  logic                resetn,
    input  logic                req_valid,
    input  addr_t               req_addr,
    input  strobe_t             req_strobe,
    input  word_t               req_wdata,
    output logic                req_ready,
    input  logic                access_done,
    output logic                req_pending,
    output index_t              held_index,
    output tag_t                held_tag,
    output word_sel_t           held_word,
    output strobe_t             held_strobe,
    output word_t               held_wdata,
    dcache_way_if.feeder        lookup [num_ways]
);

    logic busy_q;
    logic accept;

    assign accept      = req_valid && req_ready;
    assign req_ready   = !busy_q;
    assign req_pending = busy_q;

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy_q <= 1'b0;
        end else if (access_done) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_tag    <= req_addr[tag_lsb +: tag_bits];
            held_index  <= req_addr[index_lsb +: $bits(index_t)];
            held_word   <= req_addr[word_lsb +: $bits(word_sel_t)];
            held_strobe <= req_strobe;
            held_wdata  <= req_wdata;
        end
    end

    // same lookup goes to every way
    for (genvar w = 0; w < num_ways; w++) begin : g_lookup
        assign lookup[w].lookup_index = held_index;
        assign lookup[w].lookup_tag   = held_tag;
    end

endmodule

/* verilog/dcache_top.sv */
module dcache_top import dcache_pkg::*; (
    input  logic    clk,
    input  logic    resetn,
    input  logic    req_valid,
    output logic    req_ready,
    input  addr_t   req_addr,
    input  strobe_t req_strobe,
    input  word_t   req_wdata,
    output logic    resp_valid,
    input  logic    resp_ready,
    output word_t   resp_rdata,
    output logic    mem_valid,
    input  logic    mem_ready,
    output logic    mem_write,
    output addr_t   mem_addr,
    output word_t   mem_wdata,
    input  word_t   mem_rdata,
    input  logic    mem_last
);

    logic      access_done;
    logic      req_pending;
    tag_t      held_tag;
    index_t    held_index;
    word_sel_t held_word;
    strobe_t   held_strobe;
    word_t     held_wdata;
    logic      sel_hit;
    logic      sel_dirty;
    way_sel_t  sel_way;
    tag_t      sel_tag;
    line_t     sel_line;

    dcache_way_if way_bus [num_ways] ();

    dcache_req_latch i_req_latch (
        .clk         (clk),
        .resetn      (resetn),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_strobe  (req_strobe),
        .req_wdata   (req_wdata),
        .req_ready   (req_ready),
        .access_done (access_done),
        .req_pending (req_pending),
        .held_index  (held_index),
        .held_tag    (held_tag),
        .held_word   (held_word),
        .held_strobe (held_strobe),
        .held_wdata  (held_wdata),
        .lookup      (way_bus)
    );

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        dcache_way i_way (
            .clk    (clk),
            .resetn (resetn),
            .port   (way_bus[w])
        );
    end

    dcache_way_select i_way_select (
        .clk         (clk),
        .resetn      (resetn),
        .ways        (way_bus),
        .access_done (access_done),
        .sel_hit     (sel_hit),
        .sel_dirty   (sel_dirty),
        .sel_way     (sel_way),
        .sel_tag     (sel_tag),
        .sel_line    (sel_line)
    );

    dcache_ctrl i_ctrl (
        .clk         (clk),
        .resetn      (resetn),
        .req_pending (req_pending),
        .held_tag    (held_tag),
        .held_index  (held_index),
        .held_word   (held_word),
        .held_strobe (held_strobe),
        .held_wdata  (held_wdata),
        .access_done (access_done),
        .sel_hit     (sel_hit),
        .sel_way     (sel_way),
        .sel_dirty   (sel_dirty),
        .sel_tag     (sel_tag),
        .sel_line    (sel_line),
        .ways        (way_bus),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_rdata  (resp_rdata),
        .mem_valid   (mem_valid),
        .mem_ready   (mem_ready),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_last    (mem_last)
    );

endmodule

/* verilog/dcache_way.sv */
module dcache_way import dcache_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    dcache_way_if.way port
);

    logic [num_sets-1:0] valid_q;
    logic [num_sets-1:0] dirty_q;
    tag_t                tag_q  [num_sets];
    line_t               line_q [num_sets];

    index_t idx;
    logic   cur_valid;

    assign idx       = port.lookup_index;
    assign cur_valid = valid_q[idx];

    assign port.valid      = cur_valid;
    assign port.dirty      = cur_valid && dirty_q[idx];
    assign port.victim_tag = tag_q[idx];
    assign port.rd_line    = line_q[idx];
    assign port.hit        = cur_valid && (tag_q[idx] == port.lookup_tag);

    always_ff @(posedge clk) begin
        if (resetn) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (port.wr_en) begin
            valid_q[idx] <= 1'b1;
            dirty_q[idx] <= port.wr_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            tag_q[idx]  <= port.lookup_tag; // refill installs the requested tag
            line_q[idx] <= port.wr_line;
        end
    end

endmodule

/* verilog/dcache_way_if.sv */
interface dcache_way_if import dcache_pkg::*; ();

    index_t lookup_index;
    tag_t   lookup_tag;

    logic   hit;
    logic   valid;
    logic   dirty;
    tag_t   victim_tag; // stored tag at lookup_index
    line_t  rd_line;

    logic   wr_en;
    line_t  wr_line;
    logic   wr_dirty;

    modport feeder (output lookup_index, lookup_tag);

    modport way (
        input  lookup_index, lookup_tag, wr_en, wr_line, wr_dirty,
        output hit, valid, dirty, victim_tag, rd_line
    );

    modport drain (input lookup_index, hit, valid, dirty, victim_tag, rd_line);

    modport writer (output wr_en, wr_line, wr_dirty);

endinterface

/* verilog/dcache_way_select.sv */
module dcache_way_select import dcache_pkg::*; (
    input  logic         clk,
    input  logic         resetn,
    dcache_way_if.drain  ways [num_ways],
    input  logic         access_done,
    output logic         sel_hit,
    output logic         sel_dirty,
    output way_sel_t     sel_way,
    output tag_t         sel_tag,
    output line_t        sel_line
);

    logic [num_ways-1:0] hit_vec;
    logic [num_ways-1:0] valid_vec;
    logic [num_ways-1:0] dirty_vec;
    tag_t                tag_arr  [num_ways];
    line_t               line_arr [num_ways];
    plru_t               plru_q   [num_sets];

    index_t   cur_index;
    plru_t    cur_plru;
    way_sel_t hit_way;
    way_sel_t free_way;
    way_sel_t plru_way;

    for (genvar w = 0; w < num_ways; w++) begin : g_collect
        assign hit_vec[w]   = ways[w].hit;
        assign valid_vec[w] = ways[w].valid;
        assign dirty_vec[w] = ways[w].dirty;
        assign tag_arr[w]   = ways[w].victim_tag;
        assign line_arr[w]  = ways[w].rd_line;
    end

    assign cur_index = ways[0].lookup_index;
    assign cur_plru  = plru_q[cur_index];

    always_comb begin
        hit_way  = '0;
        free_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (hit_vec[w]) begin
                hit_way = way_sel_t'(w);
            end
            if (!valid_vec[w]) begin
                free_way = way_sel_t'(w); // lowest invalid wins
            end
        end
    end

    assign plru_way = cur_plru[0] ? {1'b1, cur_plru[2]} : {1'b0, cur_plru[1]};

    assign sel_hit   = |hit_vec;
    assign sel_way   = sel_hit ? hit_way : (!(&valid_vec) ? free_way : plru_way);
    assign sel_dirty = dirty_vec[sel_way];
    assign sel_tag   = tag_arr[sel_way];
    assign sel_line  = line_arr[sel_way];

    always_ff @(posedge clk) begin
        if (resetn) begin
            plru_q <= '{default: '0};
        end else if (access_done) begin
            plru_q[cur_index][0] <= ~sel_way[1]; // point to the other pair
            if (sel_way[1]) begin
                plru_q[cur_index][2] <= ~sel_way[0];
            end else begin
                plru_q[cur_index][1] <= ~sel_way[0];
            end
        end
    end

endmodule
